// File: core_bus_pkg.sv
// single word-wide bus, four-phase req/ack; byte enables and error responses not supported
package core_bus_pkg;

   // held stable by the requester while req is high
   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] wdata;
      logic        we;
   } bus_req_t;

   // rdata valid only while ack is high
   typedef struct packed {
      logic [31:0] rdata;
   } bus_rsp_t;

   typedef enum logic {
      m_fetch,
      m_data
   } master_e;

endpackage

// File: mem_arbiter.sv
// two masters, data before fetch when both wait; grant held until the owner's ack falls
`timescale 1ns/1ps

module mem_arbiter (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   f_req,
   input  core_bus_pkg::bus_req_t f_out,
   output logic                   f_ack,
   output core_bus_pkg::bus_rsp_t f_in,
   input  logic                   d_req,
   input  core_bus_pkg::bus_req_t d_out,
   output logic                   d_ack,
   output core_bus_pkg::bus_rsp_t d_in,
   output logic                   mem_req,
   output core_bus_pkg::bus_req_t mem_out,
   input  logic                   mem_ack,
   input  core_bus_pkg::bus_rsp_t mem_in
);
   import core_bus_pkg::*;

   typedef enum logic [1:0] {arb_idle, arb_busy_fetch, arb_busy_data} arb_state_e;

   arb_state_e state;
   master_e    sel;

   assign sel = (state == arb_busy_data) ? m_data : m_fetch;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= arb_idle;
      end else begin
         case (state)
            arb_idle: begin
               if (d_req)
                  state <= arb_busy_data;
               else if (f_req)
                  state <= arb_busy_fetch;
            end
            arb_busy_fetch: if (!f_req && !mem_ack) state <= arb_idle;
            arb_busy_data:  if (!d_req && !mem_ack) state <= arb_idle;
            default:        state <= arb_idle;
         endcase
      end
   end

   // only the owner sees the memory, the other one just waits
   assign mem_req = (state != arb_idle) && ((sel == m_data) ? d_req : f_req);
   assign mem_out = (sel == m_data) ? d_out : f_out;
   assign f_ack   = (state == arb_busy_fetch) && mem_ack;
   assign d_ack   = (state == arb_busy_data) && mem_ack;
   assign f_in    = (state == arb_busy_fetch) ? mem_in : '0;
   assign d_in    = (state == arb_busy_data) ? mem_in : '0;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv --timescale 1ns/1ps --top-module tb_rv_core_top \
   -f rv_core_top.f -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulator returned status $status"
   exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
   exit 1
fi
exit 0

// File: rv_alu.sv
// 32-bit integer ALU; shift amount taken from b[4:0] only, flags always compare a and b
`timescale 1ns/1ps

module rv_alu (
   input  logic [31:0]         a,
   input  logic [31:0]         b,
   input  rv_isa_pkg::alu_op_e op,
   output logic [31:0]         y,
   output logic                zero,
   output logic                lt,
   output logic                ltu
);
   import rv_isa_pkg::*;

   always_comb begin
      case (op)
         alu_add:  y = a + b;
         alu_sub:  y = a - b;
         alu_and:  y = a & b;
         alu_or:   y = a | b;
         alu_xor:  y = a ^ b;
         alu_slt:  y = {31'd0, lt};
         alu_sltu: y = {31'd0, ltu};
         alu_sll:  y = a << b[4:0];
         alu_srl:  y = a >> b[4:0];
         alu_sra:  y = $signed(a) >>> b[4:0];
         default:  y = a + b;  // unused encodings
      endcase
   end

   // branch flags
   assign zero = (y == 32'd0);
   assign lt   = $signed(a) < $signed(b);
   assign ltu  = a < b;

endmodule

// File: rv_core_top.f
+incdir+.
rv_isa_pkg.sv
core_bus_pkg.sv
rv_decoder.sv
rv_alu.sv
rv_regfile.sv
rv_datapath.sv
rv_fetch.sv
rv_lsu.sv
mem_arbiter.sv
rv_core_top.sv
tb_rv_core_top.sv

// File: rv_core_top.sv
// RV32I subset core with one shared four-phase memory port; memory lives outside
`timescale 1ns/1ps

module rv_core_top #(
   parameter logic [31:0] reset_pc = 32'h0
) (
   input  logic                   clk,
   input  logic                   rst,
   output logic                   mem_req,
   output core_bus_pkg::bus_req_t mem_out,
   input  logic                   mem_ack,
   input  core_bus_pkg::bus_rsp_t mem_in
);
   import rv_isa_pkg::*;
   import core_bus_pkg::*;

   ctrl_t       ctrl;
   logic [31:0] inst, pc, alu_y, rd2, load_data;
   logic        inst_valid, step, lsu_busy, load_done;
   logic        f_req, f_ack, d_req, d_ack;
   bus_req_t    f_out, d_out;
   bus_rsp_t    f_in, d_in;

   rv_decoder i_decoder (.inst(inst), .ctrl(ctrl));

   rv_datapath #(.reset_pc(reset_pc)) i_datapath (
      .clk(clk), .rst(rst), .inst(inst), .inst_valid(inst_valid), .ctrl(ctrl),
      .lsu_busy(lsu_busy), .load_data(load_data), .load_done(load_done),
      .pc(pc), .alu_y(alu_y), .rd2(rd2), .step(step)
   );

   rv_fetch #(.reset_pc(reset_pc)) i_fetch (
      .clk(clk), .rst(rst), .pc(pc), .step(step), .inst(inst), .inst_valid(inst_valid),
      .f_req(f_req), .f_out(f_out), .f_ack(f_ack), .f_in(f_in)
   );

   rv_lsu i_lsu (
      .clk(clk), .rst(rst), .ctrl(ctrl), .inst_valid(inst_valid), .addr(alu_y),
      .wdata(rd2), .busy(lsu_busy), .load_done(load_done), .load_data(load_data),
      .d_req(d_req), .d_out(d_out), .d_ack(d_ack), .d_in(d_in)
   );

   mem_arbiter i_arbiter (
      .clk(clk), .rst(rst),
      .f_req(f_req), .f_out(f_out), .f_ack(f_ack), .f_in(f_in),
      .d_req(d_req), .d_out(d_out), .d_ack(d_ack), .d_in(d_in),
      .mem_req(mem_req), .mem_out(mem_out), .mem_ack(mem_ack), .mem_in(mem_in)
   );

endmodule

// File: rv_datapath.sv
// one instruction per step; no forwarding needed since regfile writes land at the step edge
`timescale 1ns/1ps

module rv_datapath #(
   parameter logic [31:0] reset_pc = 32'h0
) (
   input  logic              clk,
   input  logic              rst,
   input  logic [31:0]       inst,
   input  logic              inst_valid,
   input  rv_isa_pkg::ctrl_t ctrl,
   input  logic              lsu_busy,
   input  logic [31:0]       load_data,
   input  logic              load_done,
   output logic [31:0]       pc,
   output logic [31:0]       alu_y,
   output logic [31:0]       rd2,
   output logic              step
);
   import rv_isa_pkg::*;

   typedef enum logic {exec_e, load_wait_e} dp_state_e;

   dp_state_e   state;
   logic [31:0] imm;
   logic [31:0] rd1;
   logic [31:0] src_b;
   logic [31:0] pc_plus4;
   logic [31:0] pc_plus_imm;
   logic [31:0] upper;
   logic [31:0] result;
   logic [31:0] pc_next;
   logic        zero, lt, ltu;
   logic        take_branch;
   logic        is_load;

   always_comb begin
      case (ctrl.imm_fmt)
         imm_s:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
         imm_b:   imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
         imm_u:   imm = {inst[31:12], 12'd0};
         imm_j:   imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
         default: imm = {{20{inst[31]}}, inst[31:20]};
      endcase
   end

   assign src_b = ctrl.alu_src_imm ? imm : rd2;

   rv_regfile i_regfile (
      .clk(clk), .rst(rst),
      .we(step && ctrl.reg_write),  // commit only
      .ra1(inst[19:15]), .ra2(inst[24:20]), .wa(inst[11:7]),
      .wd(result),
      .rd1(rd1), .rd2(rd2)
   );

   rv_alu i_alu (
      .a(rd1), .b(src_b), .op(ctrl.alu_op),
      .y(alu_y), .zero(zero), .lt(lt), .ltu(ltu)
   );

   always_comb begin
      case (ctrl.funct3)
         3'b000:  take_branch = zero;   // beq
         3'b001:  take_branch = !zero;  // bne
         3'b100:  take_branch = lt;
         3'b101:  take_branch = !lt;
         3'b110:  take_branch = ltu;
         3'b111:  take_branch = !ltu;
         default: take_branch = 1'b0;
      endcase
   end

   assign pc_plus4    = pc + 32'd4;
   assign pc_plus_imm = pc + imm;
   assign upper       = ctrl.is_lui ? imm : pc_plus_imm;  // lui or auipc

   always_comb begin
      if (ctrl.is_jalr)
         pc_next = {alu_y[31:1], 1'b0};
      else if (ctrl.is_jal || (ctrl.is_branch && take_branch))
         pc_next = pc_plus_imm;
      else
         pc_next = pc_plus4;
   end

   always_comb begin
      case (ctrl.result_src)
         res_mem:   result = load_data;
         res_pc4:   result = pc_plus4;
         res_upper: result = upper;
         default:   result = alu_y;
      endcase
   end

   // loads commit only with load_done, everything else once the LSU lets go
   assign is_load = (ctrl.opcode == opc_load);
   assign step    = (state == load_wait_e) ? load_done : (inst_valid && !lsu_busy && !is_load);

   always_ff @(posedge clk) begin
      if (rst) begin
         pc    <= reset_pc;
         state <= exec_e;
      end else begin
         if (step)
            pc <= pc_next;
         case (state)
            exec_e:      if (inst_valid && is_load) state <= load_wait_e;
            load_wait_e: if (load_done) state <= exec_e;
            default:     state <= exec_e;
         endcase
      end
   end

endmodule

// File: rv_decoder.sv
// unknown opcodes decode to a no-op without register write; load/store funct3 is not checked
`timescale 1ns/1ps

module rv_decoder (
   input  logic [31:0]       inst,
   output rv_isa_pkg::ctrl_t ctrl
);
   import rv_isa_pkg::*;

   logic [2:0] f3;
   logic       alt;  // funct7 bit 5

   assign f3  = inst[14:12];
   assign alt = inst[30];

   function automatic alu_op_e alu_from_funct(input logic [2:0] funct3, input logic sub_sra);
      case (funct3)
         3'b000:  return sub_sra ? alu_sub : alu_add;
         3'b001:  return alu_sll;
         3'b010:  return alu_slt;
         3'b011:  return alu_sltu;
         3'b100:  return alu_xor;
         3'b101:  return sub_sra ? alu_sra : alu_srl;
         3'b110:  return alu_or;
         default: return alu_and;
      endcase
   endfunction

   always_comb begin
      ctrl            = '0;
      ctrl.opcode     = opcode_e'(inst[6:0]);
      ctrl.alu_op     = alu_add;
      ctrl.imm_fmt    = imm_i;
      ctrl.result_src = res_alu;
      ctrl.funct3     = f3;
      case (inst[6:0])
         opc_op: begin
            ctrl.alu_op    = alu_from_funct(f3, alt);
            ctrl.reg_write = 1'b1;
         end
         opc_op_imm: begin
            ctrl.alu_op      = alu_from_funct(f3, alt && (f3 == 3'b101));  // no subi
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
         end
         opc_load: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
            ctrl.result_src  = res_mem;
         end
         opc_store: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.imm_fmt     = imm_s;
         end
         opc_branch: begin
            ctrl.alu_op    = alu_sub;  // flags compare rs1 and rs2
            ctrl.imm_fmt   = imm_b;
            ctrl.is_branch = 1'b1;
         end
         opc_lui, opc_auipc: begin
            ctrl.imm_fmt    = imm_u;
            ctrl.result_src = res_upper;
            ctrl.reg_write  = 1'b1;
            ctrl.is_lui     = (inst[6:0] == opc_lui);
         end
         opc_jal: begin
            ctrl.imm_fmt    = imm_j;
            ctrl.result_src = res_pc4;
            ctrl.reg_write  = 1'b1;
            ctrl.is_jal     = 1'b1;
         end
         opc_jalr: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.result_src  = res_pc4;
            ctrl.reg_write   = 1'b1;
            ctrl.is_jalr     = 1'b1;
         end
         default: ctrl.opcode = opc_op_imm;  // acts like addi x0 with no write
      endcase
   end

endmodule

// File: rv_fetch.sv
// word-aligned pc assumed; holds the current word plus one sequential prefetch, no branch prediction
`timescale 1ns/1ps

module rv_fetch #(
   parameter logic [31:0] reset_pc = 32'h0
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [31:0]            pc,
   input  logic                   step,
   output logic [31:0]            inst,
   output logic                   inst_valid,
   output logic                   f_req,
   output core_bus_pkg::bus_req_t f_out,
   input  logic                   f_ack,
   input  core_bus_pkg::bus_rsp_t f_in
);
   typedef enum logic [1:0] {fs_idle, fs_req, fs_wait_low} fetch_state_e;

   fetch_state_e state;
   logic [31:0]  cur_addr, cur_data;
   logic [31:0]  pf_addr, pf_data;
   logic [31:0]  req_addr;
   logic         cur_valid, pf_valid;

   assign inst       = cur_data;
   assign inst_valid = cur_valid && (cur_addr == pc);  // stale word after a redirect
   assign f_req      = (state == fs_req);
   assign f_out      = '{addr: req_addr, wdata: 32'd0, we: 1'b0};

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= fs_idle;
         cur_valid <= 1'b0;
         pf_valid  <= 1'b0;
         cur_addr  <= reset_pc;
         req_addr  <= reset_pc;
      end else begin
         if (step) begin
            cur_valid <= pf_valid;  // prefetched word moves up
            cur_addr  <= pf_addr;
            cur_data  <= pf_data;
            pf_valid  <= 1'b0;
         end
         case (state)
            fs_idle: begin
               if (!step && !inst_valid) begin
                  req_addr <= pc;
                  state    <= fs_req;
               end else if (!step && !pf_valid) begin
                  req_addr <= cur_addr + 32'd4;  // sequential prefetch
                  state    <= fs_req;
               end
            end
            fs_req: begin
               if (f_ack) begin
                  if (inst_valid && !step) begin
                     pf_valid <= 1'b1;
                     pf_addr  <= req_addr;
                     pf_data  <= f_in.rdata;
                  end else begin
                     cur_valid <= 1'b1;  // overrides the step shift above
                     cur_addr  <= req_addr;
                     cur_data  <= f_in.rdata;
                  end
                  state <= fs_wait_low;
               end
            end
            fs_wait_low: if (!f_ack) state <= fs_idle;
            default:     state <= fs_idle;
         endcase
      end
   end

endmodule

// File: rv_isa_pkg.sv
// RV32I subset only (no byte/half access, CSR, fence); opcode values follow the base ISA map
package rv_isa_pkg;

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      opc_op     = 7'b0110011,
      opc_op_imm = 7'b0010011,
      opc_load   = 7'b0000011,
      opc_store  = 7'b0100011,
      opc_branch = 7'b1100011,
      opc_lui    = 7'b0110111,
      opc_auipc  = 7'b0010111,
      opc_jal    = 7'b1101111,
      opc_jalr   = 7'b1100111
   } opcode_e;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor,
      alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
   } alu_op_e;

   typedef enum logic [2:0] {
      imm_i, imm_s, imm_b, imm_u, imm_j
   } imm_fmt_e;

   // what lands in rd
   typedef enum logic [1:0] {
      res_alu, res_mem, res_pc4, res_upper
   } result_src_e;

   typedef struct packed {
      opcode_e     opcode;
      alu_op_e     alu_op;
      imm_fmt_e    imm_fmt;
      result_src_e result_src;
      logic        alu_src_imm;  // operand b from immediate
      logic        reg_write;
      logic        is_branch;
      logic        is_jal;
      logic        is_jalr;
      logic        is_lui;       // lui vs auipc for the upper result
      logic [2:0]  funct3;       // branch condition
   } ctrl_t;

endpackage

// File: rv_lsu.sv
// word-only lw/sw, address taken as is (no alignment check); one access per instruction
`timescale 1ns/1ps

module rv_lsu (
   input  logic                   clk,
   input  logic                   rst,
   input  rv_isa_pkg::ctrl_t      ctrl,
   input  logic                   inst_valid,
   input  logic [31:0]            addr,
   input  logic [31:0]            wdata,
   output logic                   busy,
   output logic                   load_done,
   output logic [31:0]            load_data,
   output logic                   d_req,
   output core_bus_pkg::bus_req_t d_out,
   input  logic                   d_ack,
   input  core_bus_pkg::bus_rsp_t d_in
);
   import rv_isa_pkg::*;

   typedef enum logic [1:0] {ls_idle, ls_req, ls_wait_low, ls_done} lsu_state_e;

   lsu_state_e state;
   logic       is_store;
   logic       is_mem;

   assign is_store = (ctrl.opcode == opc_store);
   assign is_mem   = inst_valid && ((ctrl.opcode == opc_load) || is_store);

   // ls_done lasts one cycle, the core steps there so the access is not repeated
   assign busy      = (state == ls_idle) ? is_mem : (state != ls_done);
   assign load_done = (state == ls_done) && !is_store;
   assign d_req     = (state == ls_req);
   assign d_out     = '{addr: addr, wdata: wdata, we: is_store};  // pc frozen, so stable

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ls_idle;
      end else begin
         case (state)
            ls_idle: if (is_mem) state <= ls_req;
            ls_req: begin
               if (d_ack) begin
                  if (!is_store)
                     load_data <= d_in.rdata;
                  state <= ls_wait_low;
               end
            end
            ls_wait_low: if (!d_ack) state <= ls_done;
            default:     state <= ls_idle;  // ls_done
         endcase
      end
   end

endmodule

// File: rv_regfile.sv
// 32 x 32 registers, reads combinational, one write per clock; x0 is never written
`timescale 1ns/1ps

module rv_regfile (
   input  logic        clk,
   input  logic        rst,
   input  logic        we,
   input  logic [4:0]  ra1,
   input  logic [4:0]  ra2,
   input  logic [4:0]  wa,
   input  logic [31:0] wd,
   output logic [31:0] rd1,
   output logic [31:0] rd2
);
   logic [31:0] regs [32];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int k = 0; k < 32; k++) begin
            regs[k] <= 32'd0;
         end
      end else if (we && (wa != 5'd0)) begin
         regs[wa] <= wd;
      end
   end

   assign rd1 = regs[ra1];  // regs[0] stays zero
   assign rd2 = regs[ra2];

endmodule

// File: rv_iss.svh
// reference model of the RV32I subset, word access only, addresses wrap in a 4 KB memory
`ifndef RV_ISS_SVH
`define RV_ISS_SVH

logic [31:0] ref_mem [1024];  // model copy of program and data
logic [31:0] ref_x [32];
logic [31:0] exp_addr_q [$];  // stores in program order
logic [31:0] exp_data_q [$];

function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
   case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
         if (alt)
            return $unsigned($signed(a) >>> b[4:0]);  // sign fill
         return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
   endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
   case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
   endcase
endfunction

task automatic run_reference(input logic [31:0] halt_addr);
   logic [31:0] pc, ins, a, b, imm_i, res, nxt, ea;
   logic        wr;
   int          n;
   pc = 32'd0;
   n  = 0;
   for (int k = 0; k < 32; k++)
      ref_x[k] = 32'd0;
   while (pc != halt_addr && n < 10000) begin
      ins   = ref_mem[pc[11:2]];
      a     = ref_x[ins[19:15]];
      b     = ref_x[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      res   = 32'd0;
      wr    = 1'b1;
      nxt   = pc + 32'd4;
      case (ins[6:0])
         7'h33: res = alu_calc(ins[14:12], ins[30], a, b);
         7'h13: res = alu_calc(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
         7'h03: begin
            ea  = a + imm_i;
            res = ref_mem[ea[11:2]];
         end
         7'h23: begin
            ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            ref_mem[ea[11:2]] = b;
            exp_addr_q.push_back(ea);
            exp_data_q.push_back(b);
            wr = 1'b0;
         end
         7'h63: begin
            if (branch_taken(ins[14:12], a, b))
               nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            wr = 1'b0;
         end
         7'h37: res = {ins[31:12], 12'd0};
         7'h17: res = pc + {ins[31:12], 12'd0};
         7'h6f: begin
            res = pc + 32'd4;
            nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         7'h67: begin
            res = pc + 32'd4;
            nxt = (a + imm_i) & ~32'd1;
         end
         default: wr = 1'b0;  // unknown opcode is a no-op
      endcase
      if (wr && ins[11:7] != 5'd0)
         ref_x[ins[11:7]] = res;
      pc = nxt;
      n++;
   end
   if (pc != halt_addr) begin
      $display("reference model did not reach the halt address");
      errors++;
   end
endtask

`endif

// File: tb_rv_core_top.sv
// random program of 120 instructions at address 0, data at 0x600, register dump at 0x700
`timescale 1ns/1ps

module tb_rv_core_top;
   import core_bus_pkg::*;

   localparam int n_random = 120;       // random instructions before the dump
   localparam int dump_word = 'h700 / 4;

   logic        clk = 1'b0;
   logic        rst = 1'b1;
   logic        mem_req;
   bus_req_t    mem_out;
   logic        mem_ack = 1'b0;
   bus_rsp_t    mem_in = '0;
   bus_req_t    prev_out;
   logic        prev_req = 1'b0;
   logic        first_done = 1'b0;
   logic        pend = 1'b0;
   logic        drop_pend = 1'b0;
   logic [31:0] mem [1024];
   logic [31:0] halt_pc = 32'd4 * (n_random + 32);
   master_e     who;
   int          seed = 32'h7380_3b2d;
   int          errors = 0;
   int          wr_cnt = 0;
   int          fetch_cnt = 0;
   int          data_cnt = 0;
   int          halt_hits = 0;
   int          delay = 0;

   `include "rv_iss.svh"

   rv_core_top #(.reset_pc(32'h0)) i_rv_core_top (
      .clk(clk), .rst(rst), .mem_req(mem_req), .mem_out(mem_out),
      .mem_ack(mem_ack), .mem_in(mem_in)
   );

   always #2 clk = ~clk;

   function automatic int rnd(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   // instruction encoders working on plain int fields
   function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
   endfunction

   function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                         input int rd, input int opc);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
   endfunction

   function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
   endfunction

   function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                         input int f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
   endfunction

   function automatic logic [31:0] enc_j(input int imm, input int rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
   endfunction

   task automatic build_program();
      int i, kind, f3, imm, off, rd, rs1, rs2;
      for (int k = 0; k < 1024; k++)
         mem[k] = (k * 32'h9e37_79b9) ^ 32'h3c5a_0f1e;  // background pattern, distinct per word
      i = 0;
      while (i < n_random) begin
         kind = rnd(8);
         rd   = 1 + rnd(15);
         rs1  = rnd(16);
         rs2  = rnd(16);
         f3   = rnd(8);
         off  = 1 + rnd(4);
         if (i + off > n_random)
            off = n_random - i;  // never skip into the dump
         case (kind)
            0: mem[i] = enc_r((f3 == 0 || f3 == 5) ? rnd(2) * 'h20 : 0, rs2, rs1, f3, rd);
            1: begin
               if (f3 == 1 || f3 == 5)
                  imm = rnd(32) + ((f3 == 5) ? rnd(2) * 'h400 : 0);  // srai flag
               else
                  imm = rnd(4096);
               mem[i] = enc_i(imm, rs1, f3, rd, 'h13);
            end
            2: mem[i] = {rnd(1 << 20) * 'h1000 + rd * 'h80 + (rnd(2) ? 'h37 : 'h17)};
            3: begin
               mem[i] = enc_i('h600 + 4 * rnd(64), 0, 2, rd, 'h03);
               if (i < n_random - 1) begin
                  i++;
                  mem[i] = enc_r(0, rs2, rd, 0, rnd(16));  // uses the load at once
               end
            end
            4: mem[i] = enc_s('h600 + 4 * rnd(64), rs2, 0);
            5: begin
               f3 = rnd(6);
               if (f3 > 1)
                  f3 = f3 + 2;
               mem[i] = enc_b(off * 4, rs2, rs1, f3);
            end
            6: mem[i] = enc_j(off * 4, rd);
            default: mem[i] = enc_i((i + off) * 4, 0, 0, rd, 'h67);  // jalr from x0
         endcase
         i++;
      end
      for (int r = 0; r < 32; r++)
         mem[n_random + r] = enc_s('h700 + 4 * r, r, 0);
      mem[n_random + 32] = enc_j(0, 0);  // jal x0, 0
   endtask

   // port monitor first, then the memory responder, all on sampled values
   always @(posedge clk) begin
      if (!rst) begin
         if (mem_req && !prev_req) begin
            if (mem_ack) begin
               $display("handshake error: req rose while ack was still high at %0t", $time);
               errors++;
            end
            if (!first_done) begin
               compare_value("first mem_out.addr", mem_out.addr, 32'h0);
               compare_value("first mem_out.we", {31'd0, mem_out.we}, 32'h0);
               first_done = 1'b1;
            end
         end
         if (mem_req && prev_req && mem_out != prev_out) begin
            $display("handshake error: request changed while req was high at %0t", $time);
            errors++;
         end
         prev_req = mem_req;
         prev_out = mem_out;
      end
      if (rst) begin
         mem_ack <= 1'b0;
      end else if (!mem_ack && mem_req) begin
         if (!pend) begin
            pend  = 1'b1;
            delay = rnd(6);
         end
         if (delay == 0) begin
            pend = 1'b0;
            who  = (mem_out.we || mem_out.addr >= 32'h600) ? m_data : m_fetch;
            if (who == m_data)
               data_cnt++;
            else
               fetch_cnt++;
            if (mem_out.we) begin
               if (wr_cnt < exp_addr_q.size()) begin
                  compare_value("mem_out.addr", mem_out.addr, exp_addr_q[wr_cnt]);
                  compare_value("mem_out.wdata", mem_out.wdata, exp_data_q[wr_cnt]);
               end else begin
                  $display("memory write to 0x%h beyond the expected stores", mem_out.addr);
                  errors++;
               end
               wr_cnt++;
               mem[mem_out.addr[11:2]] = mem_out.wdata;
            end else begin
               mem_in.rdata <= mem[mem_out.addr[11:2]];
               if (mem_out.addr == halt_pc)
                  halt_hits++;
            end
            mem_ack <= 1'b1;
         end else begin
            delay--;
         end
      end else if (mem_ack && !mem_req) begin
         if (!drop_pend) begin
            drop_pend = 1'b1;
            delay     = rnd(3);
         end
         if (delay == 0) begin
            drop_pend = 1'b0;
            mem_ack  <= 1'b0;
         end else begin
            delay--;
         end
      end
   end

   initial begin
      int cyc;
      build_program();
      for (int k = 0; k < 1024; k++)
         ref_mem[k] = mem[k];
      run_reference(halt_pc);
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      cyc = 0;
      while (halt_hits < 3 && cyc < 20000) begin
         @(posedge clk);
         cyc++;
      end
      if (halt_hits < 3) begin
         $display("timeout: halt address not fetched repeatedly within 20000 cycles");
         errors++;
      end else begin
         compare_value("store count", wr_cnt, exp_addr_q.size());
         for (int r = 0; r < 32; r++)
            compare_value($sformatf("dump x%0d", r), mem[dump_word + r], ref_x[r]);
      end
      compare_value("fetch reads seen", 32'(fetch_cnt > 0), 32'd1);
      compare_value("data accesses seen", 32'(data_cnt > 0), 32'd1);
      $display("errors %0d, writes %0d of %0d, fetch reads %0d, data accesses %0d",
               errors, wr_cnt, exp_addr_q.size(), fetch_cnt, data_cnt);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule
